/* common/expu_pkg.sv */
//////////////////////////////
// Shared definitions for the exponential lanes of the softmax unit.
// Holds the bfloat16 field widths, the register placement choice and
// the integer constants of the Schraudolph approximation.
// Modules refer to these by scoped names.
//////////////////////////////

package expu_pkg;

    //////////////////////////////
    // bfloat16 format
    //////////////////////////////

    localparam int BF16_WIDTH    = 16;                      // Operand width.
    localparam int BF16_EXP_BITS = 8;                       // Exponent field width.
    localparam int BF16_MAN_BITS = 7;                       // Mantissa field width.
    localparam int BF16_BIAS     = 127;                     // Exponent bias.

    localparam logic [BF16_WIDTH-1:0] BF16_POS_INF   = 16'h7F80;
    localparam logic [BF16_WIDTH-1:0] BF16_CANON_NAN = 16'h7FC0;

    //////////////////////////////
    // Pipeline register placement
    //////////////////////////////

    typedef enum logic [1:0] {
        BEFORE = 2'd0,                                      // All registers ahead of the datapath.
        AFTER  = 2'd1,                                      // All registers behind the datapath.
        AROUND = 2'd2                                       // Datapath sits in the middle stage.
    } regs_config_e;

    //////////////////////////////
    // Approximation constants
    //////////////////////////////

    // log2(e) in unsigned fixed point with EXPU_A_FRACTION fractional bits.
    localparam int          EXPU_A_FRACTION = 10;
    localparam logic [11:0] EXPU_LOG2E_Q    = 12'd1477;

    // The mantissa correction subtracts (m * (128 - m) * GAIN) >> SHIFT.
    localparam logic [3:0]  EXPU_CORR_GAIN  = 4'd11;
    localparam int          EXPU_CORR_SHIFT = 12;

endpackage

/* expu/expu_schraudolph.sv */
//////////////////////////////
// Combinational bfloat16 exponential after Schraudolph.
// The operand is scaled by log2(e) in fixed point and the exponent
// bias is added; the integer is then read as the result bit pattern.
// NaN, overflow and underflow are saturated.
//////////////////////////////

`timescale 1ns/100ps

module expu_schraudolph #(
    parameter bit ENABLE_ROUNDING = 1'b0
) (
    input  logic [expu_pkg::BF16_WIDTH-1:0] op_i,
    output logic [expu_pkg::BF16_WIDTH-1:0] res_o
);

    localparam int W       = expu_pkg::BF16_WIDTH;
    localparam int E_BITS  = expu_pkg::BF16_EXP_BITS;
    localparam int M_BITS  = expu_pkg::BF16_MAN_BITS;
    localparam int X_WIDTH = 15;                            // Magnitude below 2^7 with 7 fraction bits.
    localparam int P_WIDTH = X_WIDTH + 12;                  // Product with the 12-bit constant.
    localparam int T_WIDTH = 18;                            // Signed room for bias plus product.

    localparam logic [E_BITS-1:0] EXP_BIAS = E_BITS'(expu_pkg::BF16_BIAS);
    localparam logic [E_BITS-1:0] EXP_BIG  = E_BITS'(expu_pkg::BF16_BIAS + M_BITS);

    localparam logic signed [T_WIDTH-1:0] T_BIAS = T_WIDTH'(expu_pkg::BF16_BIAS << M_BITS);
    localparam logic signed [T_WIDTH-1:0] T_MAX  = T_WIDTH'(((2 ** E_BITS) - 1) << M_BITS);

    localparam logic [P_WIDTH-1:0] RND_OFS =
        P_WIDTH'(ENABLE_ROUNDING) << (expu_pkg::EXPU_A_FRACTION - 1);

    logic                        op_sign;
    logic [E_BITS-1:0]           op_exp;
    logic [M_BITS-1:0]           op_man;
    logic                        is_nan;
    logic                        big_mag;
    logic [X_WIDTH-1:0]          mag_fix;
    logic [P_WIDTH-1:0]          prod;
    logic [P_WIDTH-1:0]          prod_rnd;
    logic [T_WIDTH-2:0]          prod_int;
    logic signed [T_WIDTH-1:0]   prod_s;
    logic signed [T_WIDTH-1:0]   t_val;

    assign op_sign = op_i[W-1];
    assign op_exp  = op_i[W-2 -: E_BITS];
    assign op_man  = op_i[M_BITS-1:0];

    assign is_nan  = (op_exp == '1) && (op_man != '0);
    assign big_mag = (op_exp >= EXP_BIG);                   // |x| >= 128 saturates either way.

    // Magnitude with 7 fractional bits; zero and denormal exponents flush to 0.
    always_comb begin
        mag_fix = '0;
        if (!big_mag && op_exp != '0) begin
            if (op_exp >= EXP_BIAS) begin
                mag_fix = X_WIDTH'({1'b1, op_man}) << (op_exp - EXP_BIAS);
            end else begin
                mag_fix = X_WIDTH'({1'b1, op_man}) >> (EXP_BIAS - op_exp);
            end
        end
    end

    //////////////////////////////
    // Scale and bias
    //////////////////////////////

    assign prod     = P_WIDTH'(mag_fix) * P_WIDTH'(expu_pkg::EXPU_LOG2E_Q);
    assign prod_rnd = prod + RND_OFS;
    assign prod_int = prod_rnd[expu_pkg::EXPU_A_FRACTION +: T_WIDTH-1];
    assign prod_s   = $signed({1'b0, prod_int});
    assign t_val    = op_sign ? (T_BIAS - prod_s) : (T_BIAS + prod_s);

    always_comb begin
        if (is_nan) begin
            res_o = expu_pkg::BF16_CANON_NAN;
        end else if (big_mag) begin
            res_o = op_sign ? '0 : expu_pkg::BF16_POS_INF;
        end else if (t_val <= 0) begin
            res_o = '0;                                     // Underflow.
        end else if (t_val >= T_MAX) begin
            res_o = expu_pkg::BF16_POS_INF;                 // Overflow.
        end else begin
            res_o = {1'b0, t_val[W-2:0]};
        end
    end

endmodule

/* expu/expu_correction.sv */
//////////////////////////////
// Quadratic mantissa correction for the Schraudolph result.
// Bends the linear fraction toward 2^f by subtracting a term that
// peaks in the middle of the binade. Zero, infinity and NaN pass.
//////////////////////////////

`timescale 1ns/100ps

module expu_correction (
    input  logic [expu_pkg::BF16_WIDTH-1:0] op_i,
    output logic [expu_pkg::BF16_WIDTH-1:0] res_o
);

    localparam int W          = expu_pkg::BF16_WIDTH;
    localparam int E_BITS     = expu_pkg::BF16_EXP_BITS;
    localparam int M_BITS     = expu_pkg::BF16_MAN_BITS;
    localparam int CORR_WIDTH = 2 * M_BITS + 1 + 4;         // m * (128 - m) * gain.

    logic                  op_sign;
    logic [E_BITS-1:0]     op_exp;
    logic [M_BITS-1:0]     op_man;
    logic [M_BITS:0]       man_cmpl;
    logic [CORR_WIDTH-1:0] corr_prod;
    logic [M_BITS-1:0]     corr_term;
    logic [M_BITS-1:0]     man_corr;
    logic                  pass_thru;

    assign op_sign = op_i[W-1];
    assign op_exp  = op_i[W-2 -: E_BITS];
    assign op_man  = op_i[M_BITS-1:0];

    // The term never exceeds m, so the subtraction stays in range.
    assign man_cmpl  = (M_BITS+1)'(2 ** M_BITS) - {1'b0, op_man};
    assign corr_prod = CORR_WIDTH'(op_man) * CORR_WIDTH'(man_cmpl)
                     * CORR_WIDTH'(expu_pkg::EXPU_CORR_GAIN);
    assign corr_term = M_BITS'(corr_prod >> expu_pkg::EXPU_CORR_SHIFT);
    assign man_corr  = op_man - corr_term;

    assign pass_thru = (op_i[W-2:0] == '0) || (op_exp == '1);

    always_comb begin
        if (pass_thru) begin
            res_o = op_i;                                   // Zero, infinity or NaN.
        end else begin
            res_o = {op_sign, op_exp, man_corr};
        end
    end

endmodule

/* expu/expu_row.sv */
//////////////////////////////
// One exponential lane with its pipeline registers.
// REG_POS puts the datapath at the end of the register chain, at its
// start, or in the middle stage. Each register loads on its enable
// bit, so bubbles leave the stored data in place.
//////////////////////////////

`timescale 1ns/100ps

module expu_row #(
    parameter int unsigned            NUM_REGS               = 3,
    parameter expu_pkg::regs_config_e REG_POS                = expu_pkg::AROUND,
    parameter bit                     ENABLE_ROUNDING        = 1'b0,
    parameter bit                     ENABLE_MANT_CORRECTION = 1'b1
) (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            clear_i,
    input  logic [NUM_REGS-1:0]             enable_i,
    input  logic [expu_pkg::BF16_WIDTH-1:0] op_i,
    output logic [expu_pkg::BF16_WIDTH-1:0] res_o
);

    localparam int W         = expu_pkg::BF16_WIDTH;
    localparam int MID_STAGE = NUM_REGS / 2;

    logic [W-1:0] stage_d [NUM_REGS];
    logic [W-1:0] stage_q [NUM_REGS];
    logic [W-1:0] dp_op;
    logic [W-1:0] res_sch;
    logic [W-1:0] result;

    //////////////////////////////
    // Register chain
    //////////////////////////////

    for (genvar i = 0; i < NUM_REGS; i++) begin : gen_stage
        if (REG_POS == expu_pkg::AROUND && i == MID_STAGE) begin : gen_mid
            assign stage_d[i] = result;                     // Middle stage takes the datapath.
        end else if (i == 0 && REG_POS == expu_pkg::AFTER) begin : gen_head_res
            assign stage_d[i] = result;
        end else if (i == 0) begin : gen_head_op
            assign stage_d[i] = op_i;
        end else begin : gen_link
            assign stage_d[i] = stage_q[i-1];
        end

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                stage_q[i] <= '0;
            end else if (clear_i) begin
                stage_q[i] <= '0;
            end else if (enable_i[i]) begin
                stage_q[i] <= stage_d[i];
            end
        end
    end

    //////////////////////////////
    // Datapath placement
    //////////////////////////////

    if (REG_POS == expu_pkg::BEFORE) begin : gen_before
        assign dp_op = stage_q[NUM_REGS-1];
        assign res_o = result;
    end else if (REG_POS == expu_pkg::AFTER) begin : gen_after
        assign dp_op = op_i;
        assign res_o = stage_q[NUM_REGS-1];
    end else begin : gen_around
        if (MID_STAGE == 0) begin : gen_mid_first
            assign dp_op = op_i;
        end else begin : gen_mid_inner
            assign dp_op = stage_q[MID_STAGE-1];
        end
        assign res_o = stage_q[NUM_REGS-1];
    end

    expu_schraudolph #(
        .ENABLE_ROUNDING (ENABLE_ROUNDING)
    ) u_schraudolph (
        .op_i  (dp_op),
        .res_o (res_sch)
    );

    if (ENABLE_MANT_CORRECTION) begin : gen_corr
        expu_correction u_correction (
            .op_i  (res_sch),
            .res_o (result)
        );
    end else begin : gen_no_corr
        assign result = res_sch;
    end

endmodule

/* expu/expu_ctrl.sv */
//////////////////////////////
// Valid pipeline for the exponential lanes.
// A valid bit shifts along with the data; the stage enables are the
// incoming strobe and the valid bits, so only stages that receive an
// item load.
//////////////////////////////

`timescale 1ns/100ps

module expu_ctrl #(
    parameter int unsigned NUM_REGS = 3
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  logic                valid_i,
    output logic [NUM_REGS-1:0] stage_en_o,
    output logic                valid_o
);

    logic [NUM_REGS-1:0] valid_q;
    logic [NUM_REGS:0]   valid_chain;

    // Bit i of the chain is the valid bit entering stage i.
    assign valid_chain = {valid_q, valid_i};
    assign stage_en_o  = valid_chain[NUM_REGS-1:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (clear_i) begin
            valid_q <= '0;                                  // Items in flight are dropped.
        end else begin
            valid_q <= stage_en_o;
        end
    end

    assign valid_o = valid_chain[NUM_REGS];

endmodule

/* verilog/expu_top.sv */
//////////////////////////////
// Top level of the parallel exponential unit.
// One valid controller drives NUM_LANES lanes in lock step. Lane 0
// sits in the low bits of op_i and res_o. Results appear NUM_REGS
// cycles after valid_i, with no back-pressure.
//////////////////////////////

`timescale 1ns/100ps

module expu_top #(
    parameter int unsigned            NUM_LANES              = 4,
    parameter int unsigned            NUM_REGS               = 3,
    parameter expu_pkg::regs_config_e REG_POS                = expu_pkg::AROUND,
    parameter bit                     ENABLE_ROUNDING        = 1'b0,
    parameter bit                     ENABLE_MANT_CORRECTION = 1'b1
) (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  logic                                      clear_i,
    input  logic                                      valid_i,
    input  logic [NUM_LANES*expu_pkg::BF16_WIDTH-1:0] op_i,
    output logic [NUM_LANES*expu_pkg::BF16_WIDTH-1:0] res_o,
    output logic                                      valid_o
);

    localparam int W = expu_pkg::BF16_WIDTH;

    logic [NUM_REGS-1:0] stage_en;

    //////////////////////////////
    // Valid pipeline
    //////////////////////////////

    expu_ctrl #(
        .NUM_REGS (NUM_REGS)
    ) u_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .clear_i    (clear_i),
        .valid_i    (valid_i),
        .stage_en_o (stage_en),
        .valid_o    (valid_o)
    );

    //////////////////////////////
    // Lanes
    //////////////////////////////

    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
        expu_row #(
            .NUM_REGS               (NUM_REGS),
            .REG_POS                (REG_POS),
            .ENABLE_ROUNDING        (ENABLE_ROUNDING),
            .ENABLE_MANT_CORRECTION (ENABLE_MANT_CORRECTION)
        ) u_row (
            .clk_i    (clk_i),
            .rst_ni   (rst_ni),
            .clear_i  (clear_i),
            .enable_i (stage_en),
            .op_i     (op_i[l*W +: W]),
            .res_o    (res_o[l*W +: W])
        );
    end

endmodule

/* testbench/tb_expu_top.sv */
//////////////////////////////
// Testbench for the parallel exponential unit.
// Drives random and special bfloat16 vectors on the falling edge,
// predicts every lane with an integer model and checks results,
// latency, bubbles and clear against a queue of expected vectors.
//////////////////////////////

`timescale 1ns/100ps

module tb_expu_top;

    localparam int NUM_LANES      = 4;
    localparam int NUM_REGS       = 3;
    localparam int W              = 16;
    localparam int VEC_W          = NUM_LANES * W;
    localparam bit ROUNDING       = 1'b0;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int NUM_RANDOM     = 300;

    // Approximation constants, taken from the format definition.
    localparam int LOG2E_Q   = 1477;
    localparam int A_FRAC    = 10;
    localparam int T_BIAS    = 127 * 128;
    localparam int T_MAX     = 255 * 128;
    localparam int CORR_GAIN = 11;
    localparam int CORR_SHR  = 12;

    logic             clk_i;
    logic             rst_ni;
    logic             clear_i;
    logic             valid_i;
    logic [VEC_W-1:0] op_i;
    logic [VEC_W-1:0] res_o;
    logic             valid_o;

    logic [31:0]      lfsr_state;
    logic [VEC_W-1:0] exp_queue [$];
    int               cycle_queue [$];
    int               cycle_cnt;
    int               chk_cnt;
    int               err_cnt;
    int               fail_cnt;
    bit               expect_idle;                          // res_o must read zero while set.
    string            test_name;

    expu_top #(
        .NUM_LANES              (NUM_LANES),
        .NUM_REGS               (NUM_REGS),
        .REG_POS                (expu_pkg::AROUND),
        .ENABLE_ROUNDING        (ROUNDING),
        .ENABLE_MANT_CORRECTION (1'b1)
    ) uut (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (valid_i),
        .op_i    (op_i),
        .res_o   (res_o),
        .valid_o (valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        #1ms;
        $display("Simulation did not finish within the time limit");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    //////////////////////////////
    // Stimulus and model
    //////////////////////////////

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit.
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [W-1:0] random_operand();
        logic       sgn;
        logic [6:0] man;
        int         e;
        sgn = 1'(random_bits(1));
        e   = 100 + int'(random_bits(6) % 32'd41);          // Exponent in 100..140.
        man = 7'(random_bits(7));
        return {sgn, 8'(e), man};
    endfunction

    function automatic logic [VEC_W-1:0] random_vector();
        logic [VEC_W-1:0] v;
        for (int l = 0; l < NUM_LANES; l++) begin
            v[l*W +: W] = random_operand();
        end
        return v;
    endfunction

    function automatic logic [W-1:0] exp_model(input logic [W-1:0] op);
        logic       sgn;
        int         e;
        int         m;
        int         x;
        int         q;
        int         t;
        int         cm;
        logic [W-1:0] r;
        sgn = op[15];
        e   = int'(op[14:7]);
        m   = int'(op[6:0]);
        if (e == 255 && m != 0) return 16'h7FC0;
        if (e >= 134) return sgn ? 16'h0000 : 16'h7F80;
        if (e == 0) begin
            x = 0;                                          // Zero and denormals flush.
        end else if (e >= 127) begin
            x = (128 + m) << (e - 127);
        end else begin
            x = (128 + m) >> (127 - e);
        end
        q = (x * LOG2E_Q + (ROUNDING ? (1 << (A_FRAC - 1)) : 0)) >> A_FRAC;
        t = sgn ? T_BIAS - q : T_BIAS + q;
        if (t <= 0) begin
            r = 16'h0000;
        end else if (t >= T_MAX) begin
            r = 16'h7F80;
        end else begin
            r = {1'b0, t[14:0]};
        end
        // Mantissa correction on finite non-zero results.
        if (r[14:0] != 15'd0 && r[14:7] != 8'hFF) begin
            cm     = int'(r[6:0]);
            cm     = cm - ((cm * (128 - cm) * CORR_GAIN) >> CORR_SHR);
            r[6:0] = cm[6:0];
        end
        return r;
    endfunction

    function automatic logic [VEC_W-1:0] model_vector(input logic [VEC_W-1:0] ops);
        logic [VEC_W-1:0] v;
        for (int l = 0; l < NUM_LANES; l++) begin
            v[l*W +: W] = exp_model(ops[l*W +: W]);
        end
        return v;
    endfunction

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        chk_cnt++;
        assert (actual === expected) else begin
            err_cnt++;
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        logic [VEC_W-1:0] exp_vec;
        int               sent_cycle;
        if (valid_o) begin
            assert (exp_queue.size() != 0) else begin
                fail_cnt++;
                $display("%s: valid_o high at cycle %0d with no item in flight",
                         test_name, cycle_cnt);
            end
            if (exp_queue.size() != 0) begin
                exp_vec    = exp_queue.pop_front();
                sent_cycle = cycle_queue.pop_front();
                compare_value({test_name, " latency"}, 64'(NUM_REGS),
                              64'(cycle_cnt - sent_cycle));
                for (int l = 0; l < NUM_LANES; l++) begin
                    compare_value($sformatf("%s lane %0d", test_name, l),
                                  64'(exp_vec[l*W +: W]), 64'(res_o[l*W +: W]));
                end
            end
            expect_idle = 1'b0;
        end else if (expect_idle) begin
            compare_value({test_name, " idle res_o"}, 64'd0, res_o);
        end
    endtask

    // One clock cycle: check what the DUT shows, then drive the next inputs.
    task automatic step(input logic vld, input logic [VEC_W-1:0] ops,
                        input logic [VEC_W-1:0] exp_vec, input logic clr);
        @(negedge clk_i);
        cycle_cnt++;
        check_outputs();
        if (clr) begin
            exp_queue.delete();                             // Items in flight are lost.
            cycle_queue.delete();
            expect_idle = 1'b1;
        end
        clear_i = clr;
        valid_i = vld && !clr;
        op_i    = ops;
        if (vld && !clr) begin
            exp_queue.push_back(exp_vec);
            cycle_queue.push_back(cycle_cnt);
        end
    endtask

    task automatic idle_step();
        step(1'b0, '0, '0, 1'b0);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_queue.size() != 0 && waited < TIMEOUT_CYCLES) begin
            idle_step();
            waited++;
        end
        assert (exp_queue.size() == 0) else begin
            fail_cnt++;
            $display("%s: %0d results never arrived", test_name, exp_queue.size());
        end
        idle_step();                                        // One more cycle to catch extras.
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [VEC_W-1:0] vec;
        logic             gap;
        rst_ni      = 1'b0;
        clear_i     = 1'b0;
        valid_i     = 1'b0;
        op_i        = '0;
        lfsr_state  = 32'hd244;
        cycle_cnt   = 0;
        chk_cnt     = 0;
        err_cnt     = 0;
        fail_cnt    = 0;
        expect_idle = 1'b1;
        test_name   = "reset";

        repeat (4) begin
            @(negedge clk_i);
            compare_value("reset valid_o", 64'd0, 64'(valid_o));
            compare_value("reset res_o", 64'd0, res_o);
        end
        rst_ni = 1'b1;
        repeat (2) idle_step();

        test_name = "back to back";
        repeat (NUM_RANDOM) begin
            vec = random_vector();
            step(1'b1, vec, model_vector(vec), 1'b0);
        end
        drain();

        test_name = "special";
        step(1'b1, {16'h4348, 16'h7FC1, 16'h8000, 16'h0000},
             {16'h7F80, 16'h7FC0, 16'h3F80, 16'h3F80}, 1'b0);
        idle_step();
        step(1'b1, {16'h8001, 16'h0001, 16'hC348, 16'hFFC0},
             {16'h3F80, 16'h3F80, 16'h0000, 16'h7FC0}, 1'b0);
        drain();

        test_name = "isolated";
        vec = random_vector();
        step(1'b1, vec, model_vector(vec), 1'b0);
        drain();

        test_name = "gaps";
        repeat (NUM_RANDOM) begin
            gap = 1'(random_bits(1));
            vec = random_vector();
            step(!gap, vec, model_vector(vec), 1'b0);
        end
        drain();

        test_name = "clear";
        repeat (3) begin
            vec = random_vector();
            step(1'b1, vec, model_vector(vec), 1'b0);
        end
        step(1'b0, '0, '0, 1'b1);
        repeat (5) idle_step();
        repeat (4) begin
            vec = random_vector();
            step(1'b1, vec, model_vector(vec), 1'b0);
        end
        drain();

        $display("Checks: %0d, value errors: %0d, other failures: %0d",
                 chk_cnt, err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
common/expu_pkg.sv
expu/expu_schraudolph.sv
expu/expu_correction.sv
expu/expu_row.sv
expu/expu_ctrl.sv
verilog/expu_top.sv
testbench/tb_expu_top.sv

/* Makefile */
# Verilator flow for the exponential unit.

TOOL       = verilator
TOP        = tb_expu_top
RTL_TOP    = expu_top
FILELIST   = all.f
OBJ_DIR    = obj_dir
LOG        = sim.log
FAIL_MSG   = TEST RESULT: FAIL
LINT_FLAGS = --lint-only -Wall --timing --top-module $(RTL_TOP)
SIM_FLAGS  = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
